// File: sources.f
+incdir+src
src/keypad_pkg.sv
src/lock_pkg.sv
src/key_decoder.sv
src/code_entry.sv
src/lock_controller.sv
src/buzzer_sequencer.sv
src/keypad_lock.sv
tests/keypad_lock_properties.sv
tests/tb_keypad_lock.sv

// File: src/buzzer_sequencer.sv
`timescale 1ns/1ns
`default_nettype none
`include "lock_cfg.svh"

module buzzer_sequencer (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire lock_pkg::beep_req_t beep,
    output logic                     buzzer
);
    import lock_pkg::*;

    localparam int len_of = (`LOCK_OK_LEN > `LOCK_FAIL_LEN) ? `LOCK_OK_LEN : `LOCK_FAIL_LEN;
    localparam int max_len = (`LOCK_KEY_LEN > len_of) ? `LOCK_KEY_LEN : len_of;
    localparam int half_of = (`LOCK_OK_HALF > `LOCK_FAIL_HALF) ? `LOCK_OK_HALF
                                                              : `LOCK_FAIL_HALF;
    localparam int max_half = (`LOCK_KEY_HALF > half_of) ? `LOCK_KEY_HALF : half_of;
    localparam int dur_w  = $clog2(max_len + 1);
    localparam int half_w = $clog2(max_half + 1);

    logic              active;
    logic              tone;
    beep_kind_t        kind_q;
    logic [dur_w-1:0]  dur_cnt;
    logic [half_w-1:0] half_cnt;
    logic [dur_w-1:0]  len_sel;
    logic [half_w-1:0] half_sel;
    logic              mute;

    // pitch and length per beep kind
    always_comb begin
        case (kind_q)
            beep_ok: begin
                half_sel = half_w'(`LOCK_OK_HALF);
                len_sel  = dur_w'(`LOCK_OK_LEN);
            end
            beep_fail: begin
                half_sel = half_w'(`LOCK_FAIL_HALF);
                len_sel  = dur_w'(`LOCK_FAIL_LEN);
            end
            default: begin
                half_sel = half_w'(`LOCK_KEY_HALF);
                len_sel  = dur_w'(`LOCK_KEY_LEN);
            end
        endcase
    end

    // broken fail tone, gap in the middle third
    assign mute = (kind_q == beep_fail)
               && (dur_cnt >= dur_w'(`LOCK_FAIL_LEN / 3))
               && (dur_cnt < dur_w'(2 * `LOCK_FAIL_LEN / 3));

    assign buzzer = active && tone && !mute;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active   <= 1'b0;
            tone     <= 1'b0;
            dur_cnt  <= '0;
            half_cnt <= '0;
        end else if (beep.valid) begin
            active   <= 1'b1;                   // restart on every request
            tone     <= 1'b1;
            dur_cnt  <= '0;
            half_cnt <= '0;
        end else if (active) begin
            if (half_cnt == half_sel - 1'b1) begin
                half_cnt <= '0;
                tone     <= ~tone;
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
            if (dur_cnt == len_sel - 1'b1) begin
                active <= 1'b0;
                tone   <= 1'b0;                 // ends quiet
            end else begin
                dur_cnt <= dur_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beep.valid) begin
            kind_q <= beep.kind;
        end
    end

endmodule

`default_nettype wire

// File: src/code_entry.sv
`timescale 1ns/1ns
`default_nettype none

module code_entry (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire keypad_pkg::key_event_t key_ev,
    input  wire logic                   accept_keys,
    input  wire logic                   entry_clear,
    output lock_pkg::entry_t            entry
);
    import keypad_pkg::*;

    logic [11:0] digits;
    logic [1:0]  count;
    logic        take_key;
    logic        take_digit;
    logic        wipe_key;
    logic        wipe;

    assign take_key = key_ev.valid && accept_keys;

    // a full entry ignores further digits
    assign take_digit = take_key && (key_ev.kind == key_digit) && (count != 2'd3);

    assign wipe_key = take_key && (key_ev.kind == key_clear || key_ev.kind == key_reset);
    assign wipe     = entry_clear || wipe_key;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= 2'd0;
        end else if (wipe) begin
            count <= 2'd0;
        end else if (take_digit) begin
            count <= count + 2'd1;
        end
    end

    // older digits move up one nibble
    always_ff @(posedge clk) begin
        if (take_digit && !wipe) begin
            digits <= {digits[7:0], key_ev.digit};
        end
    end

    assign entry = '{digits: digits, count: count};

endmodule

`default_nettype wire

// File: src/key_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module key_decoder (
    input  wire logic                             clk,
    input  wire logic                             arst_n,
    input  wire logic [keypad_pkg::num_keys-1:0]  keys,
    output keypad_pkg::key_event_t                key_ev
);
    import keypad_pkg::*;

    logic [num_keys-1:0] keys_q;
    logic                hit;
    key_kind_t           hit_kind;
    logic [3:0]          hit_digit;
    logic                ev_valid;
    key_kind_t           ev_kind;
    logic [3:0]          ev_digit;

    // keypad layout, anything not single-hot falls to default
    always_comb begin
        hit       = 1'b1;
        hit_kind  = key_digit;
        hit_digit = 4'd0;
        case (keys)
            16'h0008: hit_digit = 4'd0;
            16'h0080: hit_digit = 4'd1;
            16'h0040: hit_digit = 4'd2;
            16'h0020: hit_digit = 4'd3;
            16'h0800: hit_digit = 4'd4;
            16'h0400: hit_digit = 4'd5;
            16'h0200: hit_digit = 4'd6;
            16'h8000: hit_digit = 4'd7;
            16'h4000: hit_digit = 4'd8;
            16'h2000: hit_digit = 4'd9;
            16'h0001: hit_kind  = key_enter;
            16'h1000: hit_kind  = key_clear;
            16'h0100: hit_kind  = key_reset;
            16'h0010: hit_kind  = key_lock;
            default:  hit       = 1'b0;   // idle, multi-hot or unused line
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            keys_q   <= '0;
            ev_valid <= 1'b0;
        end else begin
            keys_q   <= keys;
            ev_valid <= hit && (keys != keys_q); // only on a fresh pattern
        end
    end

    always_ff @(posedge clk) begin
        ev_kind  <= hit_kind;
        ev_digit <= hit_digit;
    end

    assign key_ev = '{valid: ev_valid, kind: ev_kind, digit: ev_digit};

endmodule

`default_nettype wire

// File: src/keypad_lock.sv
`timescale 1ns/1ns
`default_nettype none

module keypad_lock (
    input  wire logic                             clk,
    input  wire logic                             arst_n,
    input  wire logic [keypad_pkg::num_keys-1:0]  keys,
    output lock_pkg::display_t                    display,
    output lock_pkg::lock_status_t                status,
    output logic                                  buzzer
);
    import keypad_pkg::*;
    import lock_pkg::*;

    key_event_t key_ev;
    entry_t     entry;
    beep_req_t  beep;
    logic       entry_clear;
    logic       accept_keys;

    key_decoder key_decoder_i (
        .clk    (clk),
        .arst_n (arst_n),
        .keys   (keys),
        .key_ev (key_ev)
    );

    code_entry code_entry_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .key_ev      (key_ev),
        .accept_keys (accept_keys),
        .entry_clear (entry_clear),
        .entry       (entry)
    );

    lock_controller lock_controller_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .key_ev      (key_ev),
        .entry       (entry),
        .entry_clear (entry_clear),
        .accept_keys (accept_keys),
        .beep        (beep),
        .display     (display),
        .status      (status)
    );

    buzzer_sequencer buzzer_sequencer_i (
        .clk    (clk),
        .arst_n (arst_n),
        .beep   (beep),
        .buzzer (buzzer)
    );

endmodule

`default_nettype wire

// File: src/keypad_pkg.sv
`default_nettype none

package keypad_pkg;

    localparam int num_keys = 16; // lines on the keypad

    typedef enum logic [2:0] {
        key_digit,
        key_enter,
        key_clear,
        key_reset,
        key_lock
    } key_kind_t;

    // one key press, valid for a single cycle
    typedef struct packed {
        logic      valid;
        key_kind_t kind;
        logic [3:0] digit; // only meaningful for key_digit
    } key_event_t;

endpackage

`default_nettype wire

// File: src/lock_cfg.svh
`ifndef LOCK_CFG_SVH
`define LOCK_CFG_SVH

// the opening code, three BCD digits
`define LOCK_PASSWORD 12'h246

// failed tries that trigger the lockout
`define LOCK_MAX_TRIES 4

// lockout countdown start, two BCD digits
`define LOCK_LOCKOUT_SECONDS 8'h20

// clock cycles per countdown step
`define LOCK_TICK_CYCLES 8

// key beep: short and mid pitch
`define LOCK_KEY_HALF 2
`define LOCK_KEY_LEN 20

// success beep: long and high pitch
`define LOCK_OK_HALF 1
`define LOCK_OK_LEN 60

// fail beep: low pitch, middle third silent
`define LOCK_FAIL_HALF 4
`define LOCK_FAIL_LEN 45

`endif

// File: src/lock_controller.sv
`timescale 1ns/1ns
`default_nettype none
`include "lock_cfg.svh"

module lock_controller (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire keypad_pkg::key_event_t key_ev,
    input  wire lock_pkg::entry_t       entry,
    output logic                        entry_clear,
    output logic                        accept_keys,
    output lock_pkg::beep_req_t         beep,
    output lock_pkg::display_t          display,
    output lock_pkg::lock_status_t      status
);
    import keypad_pkg::*;
    import lock_pkg::*;

    localparam int tick_w = $clog2(`LOCK_TICK_CYCLES + 1);

    logic              unlocked;
    logic              locked_out;
    logic [2:0]        tries;
    logic [7:0]        seconds;    // countdown, two BCD digits
    logic [tick_w-1:0] tick_cnt;
    display_t          code_q;     // code shown while open
    logic              beep_valid;
    beep_kind_t        beep_kind;
    logic              key_ok;
    logic              enter_full;
    logic              match;
    logic              last_try;
    logic              tick;

    assign key_ok     = key_ev.valid && !locked_out; // keypad dead during lockout
    assign enter_full = key_ok && (key_ev.kind == key_enter) && (entry.count == 2'd3);
    assign match      = entry.digits == `LOCK_PASSWORD;
    assign last_try   = tries == 3'(`LOCK_MAX_TRIES - 1);
    assign tick       = tick_cnt == tick_w'(`LOCK_TICK_CYCLES - 1);

    // same edge as the status update, so the display follows at once
    assign entry_clear = enter_full || (key_ok && key_ev.kind == key_lock);
    assign accept_keys = !locked_out;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            unlocked   <= 1'b0;
            locked_out <= 1'b0;
            tries      <= 3'd0;
            seconds    <= 8'h00;
            tick_cnt   <= '0;
            beep_valid <= 1'b0;
        end else begin
            beep_valid <= 1'b0;
            if (locked_out) begin
                tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
                if (tick) begin
                    seconds <= bcd2_dec(seconds);
                    if (seconds == 8'h01) begin
                        locked_out <= 1'b0;      // countdown hits 00
                    end
                end
            end else if (key_ok) begin
                case (key_ev.kind)
                    key_enter: begin
                        if (entry.count == 2'd3) begin
                            beep_valid <= 1'b1;
                            if (match) begin
                                unlocked <= 1'b1;
                                tries    <= 3'd0;
                            end else if (last_try) begin
                                unlocked   <= 1'b0;
                                locked_out <= 1'b1;
                                tries      <= 3'd0;
                                seconds    <= `LOCK_LOCKOUT_SECONDS;
                                tick_cnt   <= '0;
                            end else begin
                                unlocked <= 1'b0;
                                tries    <= tries + 3'd1;
                            end
                        end
                    end
                    key_reset: begin
                        unlocked   <= 1'b0;
                        tries      <= 3'd0;
                        beep_valid <= 1'b1;
                    end
                    key_lock: unlocked <= 1'b0;
                    default: beep_valid <= 1'b1;    // digit or clear
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        beep_kind <= enter_full ? (match ? beep_ok : beep_fail) : beep_key;
        if (enter_full && match) begin
            code_q <= entry.digits;
        end
    end

    // leading digits not yet typed stay blank
    always_comb begin
        if (locked_out) begin
            display = {4'hF, seconds};
        end else if (unlocked) begin
            display = code_q;
        end else begin
            case (entry.count)
                2'd0:    display = display_blank;
                2'd1:    display = {8'hFF, entry.digits[3:0]};
                2'd2:    display = {4'hF, entry.digits[7:0]};
                default: display = entry.digits;
            endcase
        end
    end

    assign beep   = '{valid: beep_valid, kind: beep_kind};
    assign status = '{unlocked: unlocked, locked_out: locked_out, tries: tries};

endmodule

`default_nettype wire

// File: src/lock_pkg.sv
`default_nettype none

package lock_pkg;

    typedef struct packed {
        logic [11:0] digits; // newest digit in the low nibble
        logic [1:0]  count;
    } entry_t;

    typedef enum logic [1:0] {
        beep_key,
        beep_ok,
        beep_fail
    } beep_kind_t;

    typedef struct packed {
        logic       valid;
        beep_kind_t kind;
    } beep_req_t;

    typedef struct packed {
        logic       unlocked;
        logic       locked_out;
        logic [2:0] tries;
    } lock_status_t;

    typedef logic [11:0] display_t; // three BCD digits

    localparam display_t display_blank = 12'hFFF;

    // two-digit BCD decrement
    function automatic logic [7:0] bcd2_dec(input logic [7:0] val);
        logic [7:0] res;
        if (val[3:0] == 4'd0) begin
            res = {val[7:4] - 4'd1, 4'd9};
        end else begin
            res = {val[7:4], val[3:0] - 4'd1};
        end
        return res;
    endfunction

endpackage

`default_nettype wire

// File: tests/keypad_lock_properties.sv
`timescale 1ns/1ns
`default_nettype none
`include "lock_cfg.svh"

module keypad_lock_properties (
    input wire logic                             clk,
    input wire logic                             arst_n,
    input wire logic [keypad_pkg::num_keys-1:0]  keys,
    input wire keypad_pkg::key_event_t           key_ev,
    input wire lock_pkg::beep_req_t              beep,
    input wire lock_pkg::lock_status_t           status,
    input wire logic                             buzzer
);
    import keypad_pkg::*;
    import lock_pkg::*;

    localparam int longest_beep = (`LOCK_OK_LEN > `LOCK_FAIL_LEN) ? `LOCK_OK_LEN : `LOCK_FAIL_LEN;

    int         fail_count = 0;   // read by the testbench at the end
    logic [7:0] since_beep;       // cycles since the last beep request, saturates

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            since_beep <= 8'hFF;
        end else if (beep.valid) begin
            since_beep <= 8'd0;
        end else if (since_beep != 8'hFF) begin
            since_beep <= since_beep + 8'd1;
        end
    end

    // one event per fresh single key, none for held or multi-hot keys
    event_on_new_key: assert property (@(posedge clk) disable iff (!arst_n)
        key_ev.valid |-> $past($onehot(keys)) && ($past(keys) != $past(keys, 2)))
    else begin
        fail_count++;
        $error("key event without a fresh single key");
    end

    // key beep starts high, toggles after one half period
    key_beep_toggles: assert property (@(posedge clk) disable iff (!arst_n)
        (beep.valid && beep.kind == beep_key) |=> buzzer [*`LOCK_KEY_HALF] ##1 !buzzer)
    else begin
        fail_count++;
        $error("key beep did not toggle");
    end

    key_beep_ends: assert property (@(posedge clk) disable iff (!arst_n)
        (beep.valid && beep.kind == beep_key) |-> ##(`LOCK_KEY_LEN + 1) !buzzer)
    else begin
        fail_count++;
        $error("key beep still sounding after its length");
    end

    quiet_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
        buzzer |-> since_beep < longest_beep)
    else begin
        fail_count++;
        $error("buzzer high with no beep request");
    end

    open_or_locked_out: assert property (@(posedge clk) disable iff (!arst_n)
        !(status.unlocked && status.locked_out))
    else begin
        fail_count++;
        $error("unlocked and locked_out high together");
    end

endmodule

`default_nettype wire

// File: tests/tb_keypad_lock.sv
`timescale 1ns/1ns
`default_nettype none
`include "lock_cfg.svh"

module tb_keypad_lock;
    import keypad_pkg::*;
    import lock_pkg::*;

    localparam int hold_cycles    = 3;
    localparam int release_cycles = 30;
    localparam int num_presses    = 45;   // press tasks over all tests, rounded up
    localparam int start_seconds  = 10 * (`LOCK_LOCKOUT_SECONDS >> 4)
                                    + (`LOCK_LOCKOUT_SECONDS & 15);
    localparam int lockout_cycles = start_seconds * `LOCK_TICK_CYCLES;
    localparam int cycle_limit    = num_presses * (hold_cycles + release_cycles)
                                    + lockout_cycles + 300;
    localparam int enter_latency  = 2;    // decoder register, then controller register
    localparam int beep_latency   = 3;    // plus the sequencer register

    localparam logic [15:0] enter_key = 16'h0001;
    localparam logic [15:0] clear_key = 16'h1000;
    localparam logic [15:0] reset_key = 16'h0100;
    localparam logic [15:0] lock_key  = 16'h0010;

    logic         clk;
    logic         arst_n;
    logic [15:0]  keys;
    display_t     display;
    lock_status_t status;
    logic         buzzer;

    logic [31:0]  rng_state;
    int           cycles;
    int           test_errors;
    int           total_errors;
    int           prop_fails;
    int           tests_run;
    int           tests_failed;

    keypad_lock keypad_lock_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .keys    (keys),
        .display (display),
        .status  (status),
        .buzzer  (buzzer)
    );

    bind keypad_lock keypad_lock_properties props_i (
        .clk    (clk),
        .arst_n (arst_n),
        .keys   (keys),
        .key_ev (key_ev),
        .beep   (beep),
        .status (status),
        .buzzer (buzzer)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // keypad line for each digit
    function automatic logic [15:0] digit_key(input logic [3:0] d);
        logic [15:0] k;
        case (d)
            4'd0:    k = 16'h0008;
            4'd1:    k = 16'h0080;
            4'd2:    k = 16'h0040;
            4'd3:    k = 16'h0020;
            4'd4:    k = 16'h0800;
            4'd5:    k = 16'h0400;
            4'd6:    k = 16'h0200;
            4'd7:    k = 16'h8000;
            4'd8:    k = 16'h4000;
            4'd9:    k = 16'h2000;
            default: k = 16'h0000;
        endcase
        return k;
    endfunction

    function automatic logic [7:0] to_bcd2(input int n);
        return {4'(n / 10), 4'(n % 10)};
    endfunction

    task automatic expect_eq(input string name, input logic [15:0] got, input logic [15:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    task automatic press_key(input logic [15:0] pattern);
        keys = pattern;
        repeat (hold_cycles) @(negedge clk);
        keys = '0;
        repeat (release_cycles) @(negedge clk);
    endtask

    task automatic type_code(input logic [11:0] code);
        press_key(digit_key(code[11:8]));
        press_key(digit_key(code[7:4]));
        press_key(digit_key(code[3:0]));
    endtask

    task automatic pick_wrong_code(output logic [11:0] code);
        logic [3:0] d;
        int         i;
        do begin
            for (i = 0; i < 3; i++) begin
                rng_state = lcg_next(rng_state);
                d = 4'(rng_state[23:16] % 10);
                code = {code[7:0], d};
            end
        end while (code == `LOCK_PASSWORD);
    endtask

    task automatic entry_and_clear();
        expect_eq("display", display, 12'hFFF);   // reset state first
        expect_eq("status.unlocked", status.unlocked, 1'b0);
        expect_eq("status.locked_out", status.locked_out, 1'b0);
        expect_eq("status.tries", status.tries, 3'd0);
        expect_eq("buzzer", buzzer, 1'b0);
        press_key(digit_key(4'd2));
        expect_eq("display", display, 12'hFF2);
        press_key(digit_key(4'd4));
        expect_eq("display", display, 12'hF24);
        press_key(digit_key(4'd6));
        expect_eq("display", display, 12'h246);
        press_key(digit_key(4'd0));             // entry full, ignored
        expect_eq("display", display, 12'h246);
        press_key(clear_key);
        expect_eq("display", display, 12'hFFF);
        end_test("entry");
    endtask

    task automatic unlock_and_relock();
        int latency;
        int i;
        type_code(`LOCK_PASSWORD);
        latency = 0;
        keys = enter_key;
        for (i = 1; i <= hold_cycles; i++) begin
            @(negedge clk);
            if (latency == 0 && status.unlocked) begin
                latency = i;
            end
        end
        keys = '0;
        repeat (release_cycles) @(negedge clk);
        expect_eq("unlock latency", 16'(latency), 16'(enter_latency));
        expect_eq("status.unlocked", status.unlocked, 1'b1);
        expect_eq("status.tries", status.tries, 3'd0);
        expect_eq("display", display, `LOCK_PASSWORD);
        press_key(lock_key);
        expect_eq("status.unlocked", status.unlocked, 1'b0);
        expect_eq("display", display, 12'hFFF);
        end_test("unlock");
    endtask

    task automatic wrong_code_tries();
        logic [11:0] code;
        pick_wrong_code(code);
        type_code(code);
        press_key(enter_key);
        expect_eq("status.tries", status.tries, 3'd1);
        expect_eq("display", display, 12'hFFF);
        expect_eq("status.unlocked", status.unlocked, 1'b0);
        press_key(digit_key(4'd1));
        press_key(digit_key(4'd3));
        press_key(enter_key);                    // short entry, no effect
        expect_eq("status.tries", status.tries, 3'd1);
        expect_eq("display", display, 12'hF13);
        expect_eq("status.unlocked", status.unlocked, 1'b0);
        press_key(clear_key);
        expect_eq("display", display, 12'hFFF);
        end_test("wrong code");
    endtask

    task automatic lockout_countdown();
        logic [11:0] code;
        int          n;
        int          k;
        press_key(reset_key);
        expect_eq("status.tries", status.tries, 3'd0);
        for (n = 1; n < `LOCK_MAX_TRIES; n++) begin
            pick_wrong_code(code);
            type_code(code);
            press_key(enter_key);
            expect_eq("status.tries", status.tries, 3'(n));
        end
        pick_wrong_code(code);
        type_code(code);
        keys = enter_key;
        n = 0;
        while (!status.locked_out && n < 10) begin
            @(negedge clk);
            n++;
        end
        keys = '0;
        if (!status.locked_out) begin
            $display("at %0t ns: locked_out did not rise after the last wrong code", $time);
            test_errors++;
        end
        expect_eq("status.tries", status.tries, 3'd0);
        for (k = 0; k < lockout_cycles; k++) begin
            if (k == 2 * `LOCK_TICK_CYCLES) begin
                keys = digit_key(4'd5);          // typed during lockout
            end
            if (k == 2 * `LOCK_TICK_CYCLES + hold_cycles) begin
                keys = '0;
            end
            expect_eq("status.locked_out", status.locked_out, 1'b1);
            expect_eq("display", display,
                      {4'hF, to_bcd2(start_seconds - k / `LOCK_TICK_CYCLES)});
            @(negedge clk);
        end
        expect_eq("status.locked_out", status.locked_out, 1'b0);
        expect_eq("status.tries", status.tries, 3'd0);
        expect_eq("status.unlocked", status.unlocked, 1'b0);
        expect_eq("display", display, 12'hFFF);
        end_test("lockout");
    endtask

    task automatic glitch_rejection();
        press_key(digit_key(4'd1) | digit_key(4'd2));   // two keys at once
        expect_eq("display", display, 12'hFFF);
        keys = digit_key(4'd7);                         // held long
        repeat (20) @(negedge clk);
        keys = '0;
        repeat (release_cycles) @(negedge clk);
        expect_eq("display", display, 12'hFF7);
        press_key(clear_key);
        expect_eq("display", display, 12'hFFF);
        end_test("key glitches");
    endtask

    task automatic key_beep_timing();
        keys = digit_key(4'd9);
        repeat (beep_latency) @(negedge clk);
        expect_eq("buzzer", buzzer, 1'b1);
        keys = '0;
        repeat (release_cycles) @(negedge clk);
        expect_eq("buzzer", buzzer, 1'b0);
        press_key(clear_key);
        expect_eq("buzzer", buzzer, 1'b0);
        expect_eq("display", display, 12'hFFF);
        end_test("buzzer");
    endtask

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        keys         = '0;
        rng_state    = 32'h4e26;
        cycles       = 0;
        test_errors  = 0;
        total_errors = 0;
        prop_fails   = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        entry_and_clear();
        unlock_and_relock();
        wrong_code_tries();
        lockout_countdown();
        glitch_rejection();
        key_beep_timing();
        prop_fails = keypad_lock_i.props_i.fail_count;
        $display("tests run: %0d, tests failed: %0d, check errors: %0d, assertion failures: %0d",
                 tests_run, tests_failed, total_errors, prop_fails);
        if (total_errors == 0 && prop_fails == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
